// ==== common/mem_stage_defines.svh ====
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// ====================
// Fixed ISA widths for the memory stage
// ====================

// Integer register and data word width
`define MS_XLEN 32

// Register file index width
`define MS_REG_IDX_W 5

// One strobe bit per byte lane
`define MS_STRB_W 4

// Raw instruction width
`define MS_INSTR_W 32

`endif

// ==== common/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // ====================
  // Load/store access size
  // ====================

  // Low two bits of funct3 for loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  // ====================
  // Writeback result source
  // ====================
  typedef enum logic [2:0] {
    RES_ALU  = 3'd0,
    RES_M    = 3'd1,
    RES_PC4  = 3'd2,
    RES_TGT  = 3'd3,
    RES_LOAD = 3'd4
  } res_src_e;

  // ====================
  // Trap causes carried down the pipe
  // ====================
  typedef enum logic [1:0] {
    TRAP_NONE          = 2'd0,
    TRAP_ILLEGAL       = 2'd1,
    TRAP_LDST_MISALIGN = 2'd2,
    TRAP_ECALL         = 2'd3
  } trap_code_e;

endpackage

`default_nettype wire

// ==== common/mem_stage_pkg.sv ====
`default_nettype none

`include "mem_stage_defines.svh"

package mem_stage_pkg;

  // Data word and address
  typedef logic [`MS_XLEN-1:0] xlen_t;

  // Byte write strobes
  typedef logic [`MS_STRB_W-1:0] strb_t;

  // Destination register index
  typedef logic [`MS_REG_IDX_W-1:0] reg_idx_t;

  // Raw instruction word
  typedef logic [`MS_INSTR_W-1:0] instr_t;

  // Size and signedness field of loads and stores
  typedef logic [2:0] funct3_t;

endpackage

`default_nettype wire

// ==== common/mem_op_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded load/store view shared inside the stage
interface mem_op_if;

  // Load or store present
  logic                    access_en;
  logic                    is_load;
  logic                    is_store;
  // Address does not match the access size
  logic                    misalign;
  // Incoming trap merged with misalignment
  logic                    trap;
  rv_isa_pkg::trap_code_e  trap_code;
  // Byte lane inside the word
  logic [1:0]              byte_off;
  mem_stage_pkg::xlen_t    word_addr;

  // Decoder drives everything
  modport dec (
    output access_en, is_load, is_store, misalign, trap, trap_code, byte_off, word_addr
  );

  // Memory access side
  modport acc (
    input access_en, is_load, is_store, misalign, trap, byte_off, word_addr
  );

  // Result/pipeline register side only needs the trap outcome
  modport res (
    input trap, trap_code
  );

endinterface

`default_nettype wire

// ==== hdl/mem_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defines.svh"

module mem_decode (
  input  wire logic                   mem_read_i,
  input  wire logic                   mem_write_i,
  input  wire mem_stage_pkg::funct3_t funct3_i,
  input  wire mem_stage_pkg::xlen_t   addr_i,
  input  wire logic                   trap_i,
  input  wire rv_isa_pkg::trap_code_e trap_code_i,
  mem_op_if.dec                       op
);

  rv_isa_pkg::access_size_e size;
  logic                     misalign;

  // ====================
  // Access classification
  // ====================
  assign op.is_load   = mem_read_i;
  assign op.is_store  = mem_write_i;
  assign op.access_en = mem_read_i || mem_write_i;

  // Word address and lane offset
  assign op.word_addr = {addr_i[`MS_XLEN-1:2], 2'b00};
  assign op.byte_off  = addr_i[1:0];

  // Size sits in the low two funct3 bits
  assign size = rv_isa_pkg::access_size_e'(funct3_i[1:0]);

  // ====================
  // Misalignment check
  // ====================
  always_comb begin
    misalign = 1'b0;
    // Only memory operations can misalign
    if (mem_read_i || mem_write_i) begin
      case (size)
        // Half needs an even address
        rv_isa_pkg::SIZE_HALF: misalign = addr_i[0];
        // Word needs both low bits clear
        rv_isa_pkg::SIZE_WORD: misalign = |addr_i[1:0];
        // Bytes are always aligned
        default: misalign = 1'b0;
      endcase
    end
  end

  assign op.misalign = misalign;

  // ====================
  // Trap merge
  // ====================

  // Any upstream trap or a local misalignment
  assign op.trap = trap_i || misalign;

  // Misalignment takes over the cause
  assign op.trap_code = misalign ? rv_isa_pkg::TRAP_LDST_MISALIGN : trap_code_i;

endmodule

`default_nettype wire

// ==== lsu/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defines.svh"

module mem_access (
  input  wire logic                   accept_i,
  input  wire mem_stage_pkg::funct3_t funct3_i,
  input  wire mem_stage_pkg::xlen_t   rs2_data_i,
  mem_op_if.acc                       op,
  output logic                        dmem_ren_o,
  output mem_stage_pkg::xlen_t        dmem_raddr_o,
  input  wire mem_stage_pkg::xlen_t   dmem_rdata_i,
  output logic                        dmem_we_o,
  output mem_stage_pkg::xlen_t        dmem_waddr_o,
  output mem_stage_pkg::xlen_t        dmem_wdata_o,
  output mem_stage_pkg::strb_t        dmem_wstrb_o,
  output mem_stage_pkg::xlen_t        ld_data_o
);

  rv_isa_pkg::access_size_e size;
  logic                     access_ok;
  mem_stage_pkg::strb_t     st_strb;
  logic [7:0]               ld_byte;
  logic [15:0]              ld_half;
  logic                     ld_unsigned;

  assign size        = rv_isa_pkg::access_size_e'(funct3_i[1:0]);
  assign ld_unsigned = funct3_i[2];

  // ====================
  // Memory enables
  // ====================

  // A trapped access never reaches memory
  assign access_ok = accept_i && op.access_en && !op.trap;

  assign dmem_ren_o   = access_ok && op.is_load;
  assign dmem_we_o    = access_ok && op.is_store;
  assign dmem_raddr_o = op.word_addr;
  assign dmem_waddr_o = op.word_addr;

  // ====================
  // Store formatting
  // ====================
  always_comb begin
    case (size)
      rv_isa_pkg::SIZE_BYTE: begin
        // Byte copied to every lane
        dmem_wdata_o = {4{rs2_data_i[7:0]}};
        st_strb      = `MS_STRB_W'(1) << op.byte_off;
      end
      rv_isa_pkg::SIZE_HALF: begin
        // Half copied to both halves
        dmem_wdata_o = {2{rs2_data_i[15:0]}};
        st_strb      = op.byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata_o = rs2_data_i;
        st_strb      = '1;
      end
    endcase
  end

  // Lanes only for an accepted store at a good address
  assign dmem_wstrb_o = (accept_i && op.is_store && !op.misalign) ? st_strb : '0;

  // ====================
  // Load formatting
  // ====================
  always_comb begin
    // Pick the addressed byte
    case (op.byte_off)
      2'd0:    ld_byte = dmem_rdata_i[7:0];
      2'd1:    ld_byte = dmem_rdata_i[15:8];
      2'd2:    ld_byte = dmem_rdata_i[23:16];
      default: ld_byte = dmem_rdata_i[31:24];
    endcase
    // Upper or lower half
    ld_half = op.byte_off[1] ? dmem_rdata_i[31:16] : dmem_rdata_i[15:0];
  end

  // Sign or zero extension by funct3 bit 2
  always_comb begin
    case (size)
      rv_isa_pkg::SIZE_BYTE:
        ld_data_o = {{(`MS_XLEN-8){ld_byte[7] && !ld_unsigned}}, ld_byte};
      rv_isa_pkg::SIZE_HALF:
        ld_data_o = {{(`MS_XLEN-16){ld_half[15] && !ld_unsigned}}, ld_half};
      default:
        ld_data_o = dmem_rdata_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  wire logic                 accept_i,
  input  wire logic                 is_branch_i,
  input  wire logic                 is_jalr_i,
  input  wire logic                 branch_taken_i,
  input  wire logic                 bpred_taken_i,
  input  wire mem_stage_pkg::xlen_t jb_target_i,
  input  wire mem_stage_pkg::xlen_t pred_target_i,
  input  wire mem_stage_pkg::xlen_t pc_plus4_i,
  output logic                      jalr_mispredicted_o,
  output logic                      mispredicted_o,
  output mem_stage_pkg::xlen_t      redirect_target_o
);

  logic branch_mispredicted;

  // ====================
  // Misprediction detection
  // ====================

  // Conditional branch went the other way
  assign branch_mispredicted = is_branch_i && (branch_taken_i != bpred_taken_i);

  // JALR needs both a taken guess and the right target
  assign jalr_mispredicted_o = is_jalr_i &&
                               (!bpred_taken_i || (pred_target_i != jb_target_i));

  // Flush request only for an accepted op
  assign mispredicted_o = accept_i && (branch_mispredicted || jalr_mispredicted_o);

  // ====================
  // Redirect target
  // ====================
  always_comb begin
    // Jump or taken branch target
    redirect_target_o = jb_target_i;
    // Fall through after a false taken guess
    if (branch_mispredicted && !branch_taken_i) begin
      redirect_target_o = pc_plus4_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_result (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    accept_i,
  input  wire logic                    s_valid_i,
  input  wire logic                    m_ready_i,
  input  wire logic                    reg_write_i,
  input  wire rv_isa_pkg::res_src_e    res_src_i,
  input  wire mem_stage_pkg::instr_t   instr_i,
  input  wire mem_stage_pkg::reg_idx_t rd_i,
  input  wire mem_stage_pkg::funct3_t  funct3_i,
  input  wire mem_stage_pkg::xlen_t    alu_result_i,
  input  wire mem_stage_pkg::xlen_t    pc_plus4_i,
  input  wire mem_stage_pkg::xlen_t    jb_target_i,
  input  wire mem_stage_pkg::xlen_t    m_result_i,
  input  wire mem_stage_pkg::xlen_t    ld_data_i,
  mem_op_if.res                        op,
  output mem_stage_pkg::xlen_t         result_o,
  output logic                         m_valid_o,
  output logic                         reg_write_o,
  output rv_isa_pkg::res_src_e         res_src_o,
  output mem_stage_pkg::instr_t        instr_o,
  output mem_stage_pkg::reg_idx_t      rd_o,
  output mem_stage_pkg::funct3_t       funct3_o,
  output mem_stage_pkg::xlen_t         alu_result_o,
  output mem_stage_pkg::xlen_t         ld_data_o,
  output mem_stage_pkg::xlen_t         pc_plus4_o,
  output mem_stage_pkg::xlen_t         jb_target_o,
  output mem_stage_pkg::xlen_t         m_result_o,
  output logic                         trap_o,
  output rv_isa_pkg::trap_code_e       trap_code_o
);

  // ====================
  // Forwarding result
  // ====================
  always_comb begin
    case (res_src_i)
      rv_isa_pkg::RES_M:   result_o = m_result_i;
      rv_isa_pkg::RES_PC4: result_o = pc_plus4_i;
      rv_isa_pkg::RES_TGT: result_o = jb_target_i;
      // Loads forward through a separate path
      default:             result_o = alu_result_i;
    endcase
  end

  // ====================
  // MEM/WB register, control part
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid_o   <= 1'b0;
      reg_write_o <= 1'b0;
      trap_o      <= 1'b0;
      trap_code_o <= rv_isa_pkg::TRAP_NONE;
    end else if (accept_i) begin
      m_valid_o   <= 1'b1;
      // Trapped op must not write the register file
      reg_write_o <= reg_write_i && !op.trap;
      trap_o      <= op.trap;
      trap_code_o <= op.trap_code;
    end else if (m_ready_i && !s_valid_i) begin
      // Bubble when drained with nothing offered
      m_valid_o   <= 1'b0;
      reg_write_o <= 1'b0;
      trap_o      <= 1'b0;
      trap_code_o <= rv_isa_pkg::TRAP_NONE;
    end
  end

  // Payload loads only on accept
  always_ff @(posedge clk) begin
    if (accept_i) begin
      res_src_o    <= res_src_i;
      instr_o      <= instr_i;
      rd_o         <= rd_i;
      funct3_o     <= funct3_i;
      alu_result_o <= alu_result_i;
      ld_data_o    <= ld_data_i;
      pc_plus4_o   <= pc_plus4_i;
      jb_target_o  <= jb_target_i;
      m_result_o   <= m_result_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // From execute
  input  wire logic                    s_valid_i,
  output logic                         s_ready_o,
  input  wire logic                    reg_write_i,
  input  wire logic                    mem_read_i,
  input  wire logic                    mem_write_i,
  input  wire rv_isa_pkg::res_src_e    res_src_i,
  input  wire mem_stage_pkg::instr_t   instr_i,
  input  wire mem_stage_pkg::reg_idx_t rd_i,
  input  wire mem_stage_pkg::funct3_t  funct3_i,
  input  wire mem_stage_pkg::xlen_t    alu_result_i,
  input  wire mem_stage_pkg::xlen_t    rs2_data_i,
  input  wire mem_stage_pkg::xlen_t    pc_plus4_i,
  input  wire mem_stage_pkg::xlen_t    jb_target_i,
  input  wire mem_stage_pkg::xlen_t    m_result_i,
  input  wire logic                    is_branch_i,
  input  wire logic                    is_jalr_i,
  input  wire logic                    branch_taken_i,
  input  wire logic                    bpred_taken_i,
  input  wire mem_stage_pkg::xlen_t    pred_target_i,
  input  wire logic                    trap_i,
  input  wire rv_isa_pkg::trap_code_e  trap_code_i,
  // Data memory
  output logic                         dmem_ren_o,
  output mem_stage_pkg::xlen_t         dmem_raddr_o,
  input  wire mem_stage_pkg::xlen_t    dmem_rdata_i,
  output logic                         dmem_we_o,
  output mem_stage_pkg::xlen_t         dmem_waddr_o,
  output mem_stage_pkg::xlen_t         dmem_wdata_o,
  output mem_stage_pkg::strb_t         dmem_wstrb_o,
  // To writeback
  output logic                         m_valid_o,
  input  wire logic                    m_ready_i,
  output logic                         reg_write_o,
  output rv_isa_pkg::res_src_e         res_src_o,
  output mem_stage_pkg::instr_t        instr_o,
  output mem_stage_pkg::reg_idx_t      rd_o,
  output mem_stage_pkg::funct3_t       funct3_o,
  output mem_stage_pkg::xlen_t         alu_result_o,
  output mem_stage_pkg::xlen_t         ld_data_o,
  output mem_stage_pkg::xlen_t         pc_plus4_o,
  output mem_stage_pkg::xlen_t         jb_target_o,
  output mem_stage_pkg::xlen_t         m_result_o,
  output logic                         trap_o,
  output rv_isa_pkg::trap_code_e       trap_code_o,
  // Forwarding
  output mem_stage_pkg::xlen_t         result_mem_o,
  output mem_stage_pkg::xlen_t         load_data_mem_o,
  // Redirect
  output logic                         jalr_mispredicted_o,
  output logic                         mispredicted_o,
  output mem_stage_pkg::xlen_t         redirect_target_o
);

  logic                 accept;
  mem_stage_pkg::xlen_t ld_data_mem;

  mem_op_if mem_op ();

  // ====================
  // Handshake
  // ====================

  // Stage stalls exactly when writeback stalls
  assign s_ready_o = m_ready_i;
  assign accept    = s_valid_i && m_ready_i;

  // Access decode
  mem_decode i_decode (
    .mem_read_i  (mem_read_i),
    .mem_write_i (mem_write_i),
    .funct3_i    (funct3_i),
    .addr_i      (alu_result_i),
    .trap_i      (trap_i),
    .trap_code_i (trap_code_i),
    .op          (mem_op.dec)
  );

  // Data memory and formatting
  mem_access i_access (
    .accept_i     (accept),
    .funct3_i     (funct3_i),
    .rs2_data_i   (rs2_data_i),
    .op           (mem_op.acc),
    .dmem_ren_o   (dmem_ren_o),
    .dmem_raddr_o (dmem_raddr_o),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_we_o    (dmem_we_o),
    .dmem_waddr_o (dmem_waddr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_wstrb_o (dmem_wstrb_o),
    .ld_data_o    (ld_data_mem)
  );

  // Formatted load also feeds the forwarding network
  assign load_data_mem_o = ld_data_mem;

  // Branch and JALR check
  branch_resolve i_branch (
    .accept_i            (accept),
    .is_branch_i         (is_branch_i),
    .is_jalr_i           (is_jalr_i),
    .branch_taken_i      (branch_taken_i),
    .bpred_taken_i       (bpred_taken_i),
    .jb_target_i         (jb_target_i),
    .pred_target_i       (pred_target_i),
    .pc_plus4_i          (pc_plus4_i),
    .jalr_mispredicted_o (jalr_mispredicted_o),
    .mispredicted_o      (mispredicted_o),
    .redirect_target_o   (redirect_target_o)
  );

  // Forwarding mux and MEM/WB register
  mem_result i_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept_i     (accept),
    .s_valid_i    (s_valid_i),
    .m_ready_i    (m_ready_i),
    .reg_write_i  (reg_write_i),
    .res_src_i    (res_src_i),
    .instr_i      (instr_i),
    .rd_i         (rd_i),
    .funct3_i     (funct3_i),
    .alu_result_i (alu_result_i),
    .pc_plus4_i   (pc_plus4_i),
    .jb_target_i  (jb_target_i),
    .m_result_i   (m_result_i),
    .ld_data_i    (ld_data_mem),
    .op           (mem_op.res),
    .result_o     (result_mem_o),
    .m_valid_o    (m_valid_o),
    .reg_write_o  (reg_write_o),
    .res_src_o    (res_src_o),
    .instr_o      (instr_o),
    .rd_o         (rd_o),
    .funct3_o     (funct3_o),
    .alu_result_o (alu_result_o),
    .ld_data_o    (ld_data_o),
    .pc_plus4_o   (pc_plus4_o),
    .jb_target_o  (jb_target_o),
    .m_result_o   (m_result_o),
    .trap_o       (trap_o),
    .trap_code_o  (trap_code_o)
  );

endmodule

`default_nettype wire

// ==== tb/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

  localparam int N_OPS          = 400;
  localparam int TIMEOUT_CYCLES = 2 * N_OPS + 100;

  // Expected MEM/WB record
  typedef struct packed {
    logic        reg_write;
    logic [2:0]  res_src;
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [31:0] alu_result;
    logic [31:0] ld_data;
    logic        chk_ld;
    logic [31:0] pc_plus4;
    logic [31:0] jb_target;
    logic [31:0] m_result;
    logic        trap;
    logic [1:0]  trap_code;
  } wb_rec_t;

  // Execute side
  logic                    clk, rst_n;
  logic                    s_valid, s_ready, m_valid, m_ready;
  logic                    reg_write, mem_read, mem_write;
  rv_isa_pkg::res_src_e    res_src;
  mem_stage_pkg::instr_t   instr;
  mem_stage_pkg::reg_idx_t rd;
  mem_stage_pkg::funct3_t  funct3;
  mem_stage_pkg::xlen_t    alu_result, rs2_data, pc_plus4, jb_target, m_result, pred_target;
  logic                    is_branch, is_jalr, branch_taken, bpred_taken, trap;
  rv_isa_pkg::trap_code_e  trap_code;
  // Data memory
  logic                    dmem_ren, dmem_we;
  mem_stage_pkg::xlen_t    dmem_raddr, dmem_rdata, dmem_waddr, dmem_wdata;
  mem_stage_pkg::strb_t    dmem_wstrb;
  // Writeback side
  logic                    wb_reg_write, wb_trap;
  rv_isa_pkg::res_src_e    wb_res_src;
  mem_stage_pkg::instr_t   wb_instr;
  mem_stage_pkg::reg_idx_t wb_rd;
  mem_stage_pkg::funct3_t  wb_funct3;
  mem_stage_pkg::xlen_t    wb_alu_result, wb_ld_data, wb_pc_plus4, wb_jb_target, wb_m_result;
  rv_isa_pkg::trap_code_e  wb_trap_code;
  // Forwarding and redirect
  mem_stage_pkg::xlen_t    result_mem, load_data_mem, redirect_target;
  logic                    jalr_mispredicted, mispredicted;

  integer  seed;
  int      errors, issued, acc_count, rcv_count, cycle_cnt;
  wb_rec_t exp_q[$];
  wb_rec_t stall_snap;
  logic    stalled_prev;

  mem_stage_top i_dut (
    .clk (clk), .rst_n (rst_n),
    .s_valid_i (s_valid), .s_ready_o (s_ready),
    .reg_write_i (reg_write), .mem_read_i (mem_read), .mem_write_i (mem_write),
    .res_src_i (res_src), .instr_i (instr), .rd_i (rd), .funct3_i (funct3),
    .alu_result_i (alu_result), .rs2_data_i (rs2_data), .pc_plus4_i (pc_plus4),
    .jb_target_i (jb_target), .m_result_i (m_result),
    .is_branch_i (is_branch), .is_jalr_i (is_jalr), .branch_taken_i (branch_taken),
    .bpred_taken_i (bpred_taken), .pred_target_i (pred_target),
    .trap_i (trap), .trap_code_i (trap_code),
    .dmem_ren_o (dmem_ren), .dmem_raddr_o (dmem_raddr), .dmem_rdata_i (dmem_rdata),
    .dmem_we_o (dmem_we), .dmem_waddr_o (dmem_waddr), .dmem_wdata_o (dmem_wdata),
    .dmem_wstrb_o (dmem_wstrb),
    .m_valid_o (m_valid), .m_ready_i (m_ready),
    .reg_write_o (wb_reg_write), .res_src_o (wb_res_src), .instr_o (wb_instr),
    .rd_o (wb_rd), .funct3_o (wb_funct3), .alu_result_o (wb_alu_result),
    .ld_data_o (wb_ld_data), .pc_plus4_o (wb_pc_plus4), .jb_target_o (wb_jb_target),
    .m_result_o (wb_m_result), .trap_o (wb_trap), .trap_code_o (wb_trap_code),
    .result_mem_o (result_mem), .load_data_mem_o (load_data_mem),
    .jalr_mispredicted_o (jalr_mispredicted), .mispredicted_o (mispredicted),
    .redirect_target_o (redirect_target)
  );

  // ====================
  // Memory model and reference rules
  // ====================

  // Read word is a fixed scramble of the full word address
  function automatic logic [31:0] scramble_word(input logic [31:0] addr);
    scramble_word = ({addr[7:0], addr[31:8]} ^ 32'h5a3c_96e1) + addr;
  endfunction

  function automatic logic access_misaligned(input logic rd_en, input logic wr_en,
                                             input logic [2:0] f3, input logic [31:0] addr);
    access_misaligned = 1'b0;
    if (rd_en || wr_en) begin
      if (f3[1:0] == 2'd1) access_misaligned = addr[0];
      if (f3[1:0] == 2'd2) access_misaligned = addr[1] || addr[0];
    end
  endfunction

  function automatic logic [31:0] store_data(input logic [2:0] f3, input logic [31:0] val);
    case (f3[1:0])
      2'd0:    store_data = {val[7:0], val[7:0], val[7:0], val[7:0]};
      2'd1:    store_data = {val[15:0], val[15:0]};
      default: store_data = val;
    endcase
  endfunction

  function automatic logic [3:0] store_strobe(input logic [2:0] f3, input logic [1:0] off);
    case (f3[1:0])
      2'd0:    store_strobe = 4'b0001 << off;
      2'd1:    store_strobe = off[1] ? 4'b1100 : 4'b0011;
      default: store_strobe = 4'b1111;
    endcase
  endfunction

  // Lane select followed by sign or zero extension
  function automatic logic [31:0] format_load(input logic [2:0] f3, input logic [31:0] word,
                                              input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[{off, 3'b000} +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (f3[1:0])
      2'd0:    format_load = f3[2] ? {24'd0, b} : {{24{b[7]}}, b};
      2'd1:    format_load = f3[2] ? {16'd0, h} : {{16{h[15]}}, h};
      default: format_load = word;
    endcase
  endfunction

  function automatic logic [31:0] forward_value(input logic [2:0] src);
    case (src)
      rv_isa_pkg::RES_M:   forward_value = m_result;
      rv_isa_pkg::RES_PC4: forward_value = pc_plus4;
      rv_isa_pkg::RES_TGT: forward_value = jb_target;
      default:             forward_value = alu_result;
    endcase
  endfunction

  // Reference record from the inputs offered this cycle
  function automatic wb_rec_t build_record();
    wb_rec_t r;
    logic    mis;
    mis          = access_misaligned(mem_read, mem_write, funct3, alu_result);
    r.reg_write  = reg_write && !(trap || mis);
    r.res_src    = res_src;
    r.instr      = instr;
    r.rd         = rd;
    r.funct3     = funct3;
    r.alu_result = alu_result;
    r.ld_data    = format_load(funct3, scramble_word({alu_result[31:2], 2'b00}),
                               alu_result[1:0]);
    r.chk_ld     = mem_read;
    r.pc_plus4   = pc_plus4;
    r.jb_target  = jb_target;
    r.m_result   = m_result;
    r.trap       = trap || mis;
    r.trap_code  = mis ? rv_isa_pkg::TRAP_LDST_MISALIGN : trap_code;
    return r;
  endfunction

  function automatic wb_rec_t read_outputs();
    wb_rec_t r;
    r = {wb_reg_write, wb_res_src, wb_instr, wb_rd, wb_funct3, wb_alu_result, wb_ld_data,
         1'b0, wb_pc_plus4, wb_jb_target, wb_m_result, wb_trap, wb_trap_code};
    return r;
  endfunction

  // ====================
  // Checks
  // ====================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_record(input wb_rec_t e);
    check_value("reg_write_o", 32'(wb_reg_write), 32'(e.reg_write));
    check_value("res_src_o", 32'(wb_res_src), 32'(e.res_src));
    check_value("instr_o", wb_instr, e.instr);
    check_value("rd_o", 32'(wb_rd), 32'(e.rd));
    check_value("funct3_o", 32'(wb_funct3), 32'(e.funct3));
    check_value("alu_result_o", wb_alu_result, e.alu_result);
    check_value("pc_plus4_o", wb_pc_plus4, e.pc_plus4);
    check_value("jb_target_o", wb_jb_target, e.jb_target);
    check_value("m_result_o", wb_m_result, e.m_result);
    check_value("trap_o", 32'(wb_trap), 32'(e.trap));
    check_value("trap_code_o", 32'(wb_trap_code), 32'(e.trap_code));
    // Load data only has meaning for loads
    if (e.chk_ld) check_value("ld_data_o", wb_ld_data, e.ld_data);
  endtask

  // Combinational outputs in an accept cycle
  task automatic check_access();
    logic        mis, trap_m, br_mis, jalr_mis;
    logic [1:0]  off;
    logic [31:0] waddr;
    mis      = access_misaligned(mem_read, mem_write, funct3, alu_result);
    trap_m   = trap || mis;
    off      = alu_result[1:0];
    waddr    = {alu_result[31:2], 2'b00};
    br_mis   = is_branch && (branch_taken != bpred_taken);
    jalr_mis = is_jalr && (!bpred_taken || (pred_target != jb_target));
    check_value("dmem_we_o", 32'(dmem_we), 32'(mem_write && !trap_m));
    check_value("dmem_ren_o", 32'(dmem_ren), 32'(mem_read && !trap_m));
    check_value("dmem_wstrb_o", 32'(dmem_wstrb),
                32'((mem_write && !mis) ? store_strobe(funct3, off) : 4'b0000));
    if (mem_write) begin
      check_value("dmem_waddr_o", dmem_waddr, waddr);
      check_value("dmem_wdata_o", dmem_wdata, store_data(funct3, rs2_data));
    end
    if (mem_read) begin
      check_value("dmem_raddr_o", dmem_raddr, waddr);
      check_value("load_data_mem_o", load_data_mem,
                  format_load(funct3, scramble_word(waddr), off));
    end
    check_value("result_mem_o", result_mem, forward_value(res_src));
    check_value("jalr_mispredicted_o", 32'(jalr_mispredicted), 32'(jalr_mis));
    check_value("mispredicted_o", 32'(mispredicted), 32'(br_mis || jalr_mis));
    check_value("redirect_target_o", redirect_target,
                (br_mis && !branch_taken) ? pc_plus4 : jb_target);
  endtask

  // Compare process samples everything on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      check_value("m_valid_o", 32'(m_valid), 32'd0);
    end else begin
      check_value("s_ready_o", 32'(s_ready), 32'(m_ready));
      if (acc_count == 0) check_value("m_valid_o", 32'(m_valid), 32'd0);
      // Stalled record must not move
      if (stalled_prev) begin
        assert (m_valid && (read_outputs() == stall_snap)) else begin
          errors++;
          $display("WB outputs changed while the stage was stalled at %0t", $time);
        end
      end
      if (m_valid && m_ready) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("Output transfer at %0t without any accepted record", $time);
        end
        if (exp_q.size() > 0) begin
          compare_record(exp_q.pop_front());
          rcv_count++;
        end
      end
      stalled_prev = m_valid && !m_ready;
      stall_snap   = read_outputs();
      // Input side
      if (s_valid && m_ready) begin
        check_access();
        exp_q.push_back(build_record());
        acc_count++;
      end else begin
        check_value("dmem_we_o", 32'(dmem_we), 32'd0);
        check_value("dmem_ren_o", 32'(dmem_ren), 32'd0);
        check_value("dmem_wstrb_o", 32'(dmem_wstrb), 32'd0);
        check_value("mispredicted_o", 32'(mispredicted), 32'd0);
      end
    end
  end

  // ====================
  // Stimulus
  // ====================
  assign dmem_rdata = scramble_word(dmem_raddr);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic gen_operation();
    logic [31:0] r0, r1, r2, addr, tgt;
    logic [2:0]  f3;
    r0   = $random(seed);
    r1   = $random(seed);
    r2   = $random(seed);
    addr = $random(seed);
    tgt  = $random(seed);
    // Kind field picks load (0 to 2), store (3 to 5) or a plain op
    if (r0[2:0] <= 3'd2) begin
      case (r0[10:8])
        3'd0, 3'd5: f3 = 3'd0;
        3'd1, 3'd6: f3 = 3'd1;
        3'd2, 3'd7: f3 = 3'd2;
        3'd3:       f3 = 3'd4;
        default:    f3 = 3'd5;
      endcase
    end else if (r0[2:0] <= 3'd5) begin
      f3 = {1'b0, (r0[9:8] == 2'd3) ? 2'd2 : r0[9:8]};
    end else begin
      f3 = r0[10:8];
    end
    // Half the accesses get aligned on purpose
    if (r1[22] && f3[1:0] == 2'd1) addr[0] = 1'b0;
    if (r1[22] && f3[1:0] == 2'd2) addr[1:0] = 2'b00;
    s_valid      <= (r0[5:3] != 3'd0);
    mem_read     <= (r0[2:0] <= 3'd2);
    mem_write    <= (r0[2:0] >= 3'd3) && (r0[2:0] <= 3'd5);
    funct3       <= f3;
    alu_result   <= addr;
    res_src      <= (r0[2:0] <= 3'd2) ? rv_isa_pkg::RES_LOAD
                  : rv_isa_pkg::res_src_e'((r1[16:14] > 3'd4) ? 3'd0 : r1[16:14]);
    is_branch    <= (r0[2:0] >= 3'd6) && r1[17];
    is_jalr      <= (r0[2:0] >= 3'd6) && !r1[17] && r1[18];
    branch_taken <= r1[19];
    bpred_taken  <= r1[20];
    jb_target    <= tgt;
    pred_target  <= r1[21] ? tgt : r2;
    instr        <= $random(seed);
    rd           <= r1[4:0];
    reg_write    <= r1[5];
    rs2_data     <= $random(seed);
    pc_plus4     <= $random(seed);
    m_result     <= $random(seed);
    // Roughly one op in eight carries an upstream trap
    trap         <= (r1[8:6] == 3'd0);
    trap_code    <= (r1[8:6] != 3'd0) ? rv_isa_pkg::TRAP_NONE
                  : (r1[10:9] == 2'd0) ? rv_isa_pkg::TRAP_ILLEGAL
                  : rv_isa_pkg::trap_code_e'(r1[10:9]);
  endtask

  // Timeout watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, %0d of %0d records received, %0d errors",
             cycle_cnt, rcv_count, N_OPS, errors);
    $display("Something failed");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    seed         = 32'h0a31b0fc;
    errors       = 0;
    issued       = 0;
    acc_count    = 0;
    rcv_count    = 0;
    stalled_prev = 1'b0;
    rst_n        = 1'b0;
    s_valid      = 1'b0;
    m_ready      = 1'b0;
    reg_write    = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    res_src      = rv_isa_pkg::RES_ALU;
    instr        = '0;
    rd           = '0;
    funct3       = '0;
    alu_result   = '0;
    rs2_data     = '0;
    pc_plus4     = '0;
    jb_target    = '0;
    m_result     = '0;
    is_branch    = 1'b0;
    is_jalr      = 1'b0;
    branch_taken = 1'b0;
    bpred_taken  = 1'b0;
    pred_target  = '0;
    trap         = 1'b0;
    trap_code    = rv_isa_pkg::TRAP_NONE;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    while (issued < N_OPS) begin
      @(posedge clk);
      // Transfer took place at this edge
      if (s_valid && s_ready) issued++;
      rnd = $random(seed);
      m_ready <= (rnd[1:0] != 2'd0);
      if (issued >= N_OPS) begin
        s_valid <= 1'b0;
      end else if (!(s_valid && !s_ready)) begin
        gen_operation();
      end
    end
    // Drain the register
    m_ready <= 1'b1;
    while (rcv_count < N_OPS) @(posedge clk);
    repeat (2) @(posedge clk);
    assert ((exp_q.size() == 0) && (acc_count == N_OPS)) else begin
      errors++;
      $display("Accepted and received record counts do not match at the end");
    end
    $display("Run done: %0d accepted, %0d received, %0d errors",
             acc_count, rcv_count, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/rv_isa_pkg.sv
common/mem_stage_pkg.sv
common/mem_op_if.sv
hdl/mem_decode.sv
lsu/mem_access.sv
hdl/branch_resolve.sv
hdl/mem_result.sv
hdl/mem_stage_top.sv
tb/mem_stage_tb.sv

// ==== Makefile ====
# Verilator flow for the memory stage

TOP := mem_stage_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
